//--- Makefile
# Verilator build and run of the bus glue testbench

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/10ps -f all.f --top-module tbU712 -o simU712

run: compile
	./obj_dir/simU712 | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- all.f
u712Pkg.sv
cycleDecode.sv
regCycle.sv
ramCycle.sv
transferAck.sv
u712Top.sv
tbU712.sv

//--- cycleDecode.sv
// Transfer capture on TS, space and line decode, byte enables and start pulses
`timescale 1ns/10ps

module cycleDecode (
    input  logic             nTS,
    input  logic             TS_RST,
    input  logic             ts,
    input  u712Pkg::cpuAddrT addr,
    input  u712Pkg::sizeT    siz,
    input  logic             rnW,
    input  logic             lastAck,
    output logic             regStart,
    output logic             ramStart,
    output logic             tbiStart,
    output logic             busy,
    output u712Pkg::cpuAddrT reqAddr,
    output logic             reqRnW,
    output logic             reqBurst,
    output u712Pkg::laneT    lanes
);
    import u712Pkg::*;

    sizeT reqSiz;
    logic capture;
    logic pending;
    logic regSpace;

    // New transfer only when idle
    assign capture = ts & ~busy;
    assign regSpace = reqAddr[regSpaceBit];

    // Busy and start pulses
    always_ff @(posedge nTS or posedge TS_RST) begin
        if (TS_RST) begin
            busy <= 1'b0;
            pending <= 1'b0;
            regStart <= 1'b0;
            ramStart <= 1'b0;
            tbiStart <= 1'b0;
        end else begin
            pending <= capture;
            // One pulse, one cycle after capture
            regStart <= pending & regSpace & ~reqBurst;
            ramStart <= pending & ~regSpace;
            tbiStart <= pending & regSpace & reqBurst;
            if (capture) begin
                busy <= 1'b1;
            end else if (lastAck) begin
                busy <= 1'b0;
            end
        end
    end

    // Request held for the whole transfer
    always_ff @(posedge nTS or posedge TS_RST) begin
        if (TS_RST) begin
            reqAddr <= '0;
            reqSiz <= sizeLong;
            reqRnW <= 1'b1;
            reqBurst <= 1'b0;
        end else if (capture) begin
            reqAddr <= addr;
            reqSiz <= siz;
            reqRnW <= rnW;
            reqBurst <= (siz == sizeLine);
        end
    end

    // Byte enables from size and A[1:0]
    always_comb begin
        if (!busy) begin
            lanes = 4'b1111;
        end else begin
            case (reqSiz)
                // Offset 0 is the upper-upper lane
                sizeByte: lanes = ~(laneT'(4'b1000) >> reqAddr[1:0]);
                sizeWord: lanes = reqAddr[1] ? 4'b1100 : 4'b0011;
                // Long and line
                default:  lanes = 4'b0000;
            endcase
        end
    end

endmodule

//--- ramCycle.sv
// Chip RAM cycle with row and column multiplexing and four-beat line bursts
`timescale 1ns/10ps

module ramCycle #(
    parameter int rasToCas = u712Pkg::rasToCasDefault
) (
    input  logic             nTS,
    input  logic             TS_RST,
    input  logic             ramStart,
    input  u712Pkg::cpuAddrT reqAddr,
    input  logic             rnW,
    input  logic             burst,
    output logic             nRas,
    output logic             nCas,
    output logic             nWe,
    output u712Pkg::ramAddrT cma,
    output logic             ramBeat
);
    import u712Pkg::*;

    ramStateT state;
    beatT beat;
    logic [1:0] rasDly;
    ramAddrT rowAddr;
    ramAddrT colAddr;
    logic lastBeat;

    // Row is the upper word address, column the lower
    assign rowAddr = reqAddr[20:11];
    // Low column bits wrap inside the line
    assign colAddr = {reqAddr[10:3], beatT'(reqAddr[2:1] + beat)};
    assign lastBeat = ~burst | (beat == 2'd3);

    ////////////////////////////////////////////////////////////////////////////
    // RAM cycle FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge nTS or posedge TS_RST) begin
        if (TS_RST) begin
            state <= ramIdle;
            beat <= 2'd0;
            rasDly <= 2'd0;
            nRas <= 1'b1;
            nCas <= 1'b1;
            nWe <= 1'b1;
            cma <= '0;
            ramBeat <= 1'b0;
        end else begin
            ramBeat <= 1'b0;
            case (state)
                ramIdle: begin
                    if (ramStart) begin
                        nRas <= 1'b0;
                        cma <= rowAddr;
                        beat <= 2'd0;
                        rasDly <= 2'(rasToCas - 1);
                        state <= ramRow;
                    end
                end
                ramRow: begin
                    // RAS to CAS delay
                    if (rasDly == 2'd0) begin
                        nCas <= 1'b0;
                        nWe <= rnW;
                        cma <= colAddr;
                        state <= ramCas;
                    end else begin
                        rasDly <= rasDly - 2'd1;
                    end
                end
                ramCas: begin
                    if (!nCas) begin
                        // CAS high half, flag the beat
                        nCas <= 1'b1;
                        ramBeat <= 1'b1;
                        if (lastBeat) begin
                            nRas <= 1'b1;
                            nWe <= 1'b1;
                            state <= ramPrecharge;
                        end else begin
                            beat <= beat + 2'd1;
                        end
                    end else begin
                        // Next column of the burst
                        nCas <= 1'b0;
                        cma <= colAddr;
                    end
                end
                ramPrecharge: begin
                    state <= ramIdle;
                end
            endcase
        end
    end

endmodule

//--- regCycle.sv
// 68000-style chipset register cycle on nAs, nUds and nLds with nDtack wait
`timescale 1ns/10ps

module regCycle (
    input  logic          nTS,
    input  logic          TS_RST,
    input  logic          regStart,
    input  u712Pkg::laneT lanes,
    input  logic          rnW,
    input  logic          nDtack,
    output logic          nAs,
    output logic          nUds,
    output logic          nLds,
    output logic          regDone
);
    import u712Pkg::*;

    regStateT state;
    logic upperOn;
    logic lowerOn;

    // Either lane of a half enables its data strobe
    assign upperOn = ~(lanes[3] & lanes[2]);
    assign lowerOn = ~(lanes[1] & lanes[0]);

    ////////////////////////////////////////////////////////////////////////////
    // Register cycle FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge nTS or posedge TS_RST) begin
        if (TS_RST) begin
            state <= regIdle;
            nAs <= 1'b1;
            nUds <= 1'b1;
            nLds <= 1'b1;
            regDone <= 1'b0;
        end else begin
            regDone <= 1'b0;
            case (state)
                regIdle: begin
                    if (regStart) begin
                        // Address and data strobes together
                        nAs <= 1'b0;
                        nUds <= ~upperOn;
                        nLds <= ~lowerOn;
                        // Writes get one extra state for data setup
                        state <= rnW ? regWait : regStrobe;
                    end
                end
                regStrobe: begin
                    state <= regWait;
                end
                regWait: begin
                    // Held here for as long as the chipset stalls
                    if (!nDtack) begin
                        state <= regEnd;
                    end
                end
                regEnd: begin
                    nAs <= 1'b1;
                    nUds <= 1'b1;
                    nLds <= 1'b1;
                    regDone <= 1'b1;
                    state <= regIdle;
                end
            endcase
        end
    end

endmodule

//--- tbU712.sv
// Directed testbench for the bus glue with clock, reset, watchdog, test tasks and summary
`timescale 1ns/10ps

module tbU712;
    import u712Pkg::*;

    localparam int clockPeriod = 40;
    localparam int resetCycles = 8;
    localparam int rasToCas = 2;
    // Longest transfer in cycles with margin, and transfers over all tests
    localparam int longestCycles = 24;
    localparam int transferCount = 27;
    localparam int watchdogNs =
        (resetCycles + 4 + transferCount * longestCycles) * clockPeriod * 2;
    // Bound on any wait for nTa
    localparam int ackLimit = 40;

    logic nTS;
    logic TS_RST;
    logic ts;
    cpuAddrT addr;
    sizeT siz;
    logic rnW;
    logic [1:0] tt;
    logic nDtack;
    logic nTa;
    logic nTbi;
    logic nAs;
    logic nUds;
    logic nLds;
    logic nUube;
    logic nUmbe;
    logic nLmbe;
    logic nLlbe;
    logic nRas;
    logic nCas;
    logic nWe;
    ramAddrT cma;

    string testName;
    int errCount = 0;
    int testErrStart = 0;
    int testsRun = 0;
    int testsFailed = 0;

    u712Top #(
        .rasToCas (rasToCas)
    ) uut (
        .nTS    (nTS),
        .TS_RST (TS_RST),
        .ts     (ts),
        .addr   (addr),
        .siz    (siz),
        .rnW    (rnW),
        .tt     (tt),
        .nDtack (nDtack),
        .nTa    (nTa),
        .nTbi   (nTbi),
        .nAs    (nAs),
        .nUds   (nUds),
        .nLds   (nLds),
        .nUube  (nUube),
        .nUmbe  (nUmbe),
        .nLmbe  (nLmbe),
        .nLlbe  (nLlbe),
        .nRas   (nRas),
        .nCas   (nCas),
        .nWe    (nWe),
        .cma    (cma)
    );

    always #(clockPeriod / 2) nTS = ~nTS;

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    // Drive and sample 5 ns after each rising edge
    task automatic nextCycle();
        @(posedge nTS);
        #5;
    endtask

    task automatic compareValue(input string what, input int expected, input int actual);
        assert (actual === expected) else begin
            $display("[FAIL] %s %s expected %h actual %h", testName, what, expected, actual);
            errCount++;
        end
    endtask

    task automatic requireTrue(input string what, input bit cond);
        assert (cond) else begin
            $display("[ERROR] %s %s", testName, what);
            errCount++;
        end
    endtask

    task automatic startTest(input string name);
        testName = name;
        testErrStart = errCount;
    endtask

    task automatic closeTest();
        testsRun++;
        if (errCount == testErrStart) begin
            $display("%-12s ok", testName);
        end else begin
            testsFailed++;
            $display("%-12s %0d errors", testName, errCount - testErrStart);
        end
    endtask

    // All active-low strobes, acknowledges and byte enables
    function automatic logic [11:0] strobeState();
        return {nTa, nTbi, nAs, nUds, nLds, nUube, nUmbe, nLmbe, nLlbe, nRas, nCas, nWe};
    endfunction

    // Lane rule, bit 3 is the upper-upper lane, low is enabled
    function automatic laneT expectedLanes(input sizeT s, input logic [1:0] off);
        laneT l;
        case (s)
            sizeByte: begin
                case (off)
                    2'd0: l = 4'b0111;
                    2'd1: l = 4'b1011;
                    2'd2: l = 4'b1101;
                    default: l = 4'b1110;
                endcase
            end
            sizeWord: l = off[1] ? 4'b1100 : 4'b0011;
            default: l = 4'b0000;
        endcase
        return l;
    endfunction

    // One-cycle TS, address scrambled after capture to prove it is latched
    task automatic issueTransfer(input cpuAddrT a, input sizeT s, input logic rd,
                                 input logic [1:0] t);
        ts = 1'b1;
        addr = a;
        siz = s;
        rnW = rd;
        tt = t;
        nextCycle();
        ts = 1'b0;
        addr = cpuAddrT'($urandom);
    endtask

    // Wait for a single nTa, then one more cycle so busy has cleared
    task automatic awaitFinalAck();
        int n;
        n = 0;
        while (nTa !== 1'b0 && n < ackLimit) begin
            nextCycle();
            n++;
        end
        requireTrue("nTa never fell", nTa === 1'b0);
        nextCycle();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic resetStateTest();
        int i;
        startTest("reset");
        TS_RST = 1'b1;
        for (i = 0; i < resetCycles; i++) begin
            nextCycle();
            compareValue("strobes in reset", 'hfff, int'(strobeState()));
        end
        TS_RST = 1'b0;
        for (i = 0; i < 3; i++) begin
            nextCycle();
            compareValue("strobes after reset", 'hfff, int'(strobeState()));
        end
        closeTest();
    endtask

    // Register space with nDtack held low keeps each transfer short
    task automatic byteEnableTest();
        int s;
        int off;
        cpuAddrT a;
        startTest("byteEnable");
        nDtack = 1'b0;
        for (s = 0; s < 4; s++) begin
            for (off = 0; off < 4; off++) begin
                a = cpuAddrT'($urandom);
                a[20] = 1'b1;
                a[1:0] = off[1:0];
                issueTransfer(a, sizeT'(s), 1'b1, 2'b00);
                compareValue($sformatf("lanes siz=%0d a=%0d", s, off),
                             int'(expectedLanes(sizeT'(s), off[1:0])),
                             int'({nUube, nUmbe, nLmbe, nLlbe}));
                awaitFinalAck();
                compareValue("lanes idle", 'hf, int'({nUube, nUmbe, nLmbe, nLlbe}));
            end
        end
        nDtack = 1'b1;
        closeTest();
    endtask

    task automatic regAccessTest();
        int i;
        int n;
        int fell;
        int rise;
        int ack;
        int lowCount;
        int delay;
        int dtackAt;
        cpuAddrT a;
        sizeT s;
        logic rd;
        laneT exp;
        startTest("regAccess");
        for (i = 0; i < 8; i++) begin
            s = i[1] ? sizeWord : sizeByte;
            rd = i[0];
            a = cpuAddrT'($urandom);
            a[20] = 1'b1;
            delay = $urandom_range(0, 5);
            exp = expectedLanes(s, a[1:0]);
            issueTransfer(a, s, rd, 2'b00);
            n = 0;
            fell = -1;
            rise = -1;
            ack = -1;
            dtackAt = -1;
            lowCount = 0;
            while (ack < 0 && n < ackLimit) begin
                nextCycle();
                n++;
                if (nAs === 1'b0) begin
                    if (fell < 0) begin
                        fell = n;
                    end
                    compareValue("nUds", int'(exp[3] & exp[2]), int'(nUds));
                    compareValue("nLds", int'(exp[1] & exp[0]), int'(nLds));
                    // Chipset answers after its random delay
                    if (lowCount >= delay) begin
                        if (dtackAt < 0) begin
                            dtackAt = n;
                        end
                        nDtack = 1'b0;
                    end
                    lowCount++;
                end else if (fell >= 0 && rise < 0) begin
                    rise = n;
                    nDtack = 1'b1;
                end
                if (nTa === 1'b0) begin
                    ack = n;
                end
                requireTrue("nTbi fell during register cycle", nTbi === 1'b1);
                compareValue("RAM strobes", 'h7, int'({nRas, nCas, nWe}));
            end
            compareValue("nAs fall cycle", 2, fell);
            // Strobes rise on the edge after nDtack is sampled low
            if (rd) begin
                compareValue("strobe release cycle", dtackAt + 2, rise);
            end else begin
                requireTrue("strobes rose before nDtack was sampled",
                            dtackAt > 0 && rise >= dtackAt + 2);
            end
            compareValue("nTa cycle", rise + 1, ack);
            nextCycle();
            compareValue("nTa width", 1, int'(nTa));
        end
        closeTest();
    endtask

    // Fixed two-cycle inhibit answer
    task automatic regLineTest();
        int n;
        cpuAddrT a;
        startTest("regLine");
        a = cpuAddrT'($urandom);
        a[20] = 1'b1;
        issueTransfer(a, sizeLine, 1'b1, 2'b00);
        for (n = 1; n <= 4; n++) begin
            nextCycle();
            requireTrue("nAs fell on inhibited line", nAs === 1'b1);
            if (n == 2) begin
                compareValue("nTa nTbi at 2", 0, int'({nTa, nTbi}));
            end else begin
                compareValue($sformatf("nTa nTbi at %0d", n), 'h3, int'({nTa, nTbi}));
            end
        end
        closeTest();
    endtask

    task automatic ramWriteTest();
        int n;
        int k;
        int casAt;
        int ackAt;
        cpuAddrT a;
        startTest("ramWrite");
        a = cpuAddrT'($urandom);
        a[20] = 1'b0;
        issueTransfer(a, sizeLong, 1'b0, 2'b00);
        n = 0;
        casAt = -1;
        ackAt = -1;
        while (ackAt < 0 && n < ackLimit) begin
            nextCycle();
            n++;
            if (n < 2) begin
                requireTrue("nRas fell early", nRas === 1'b1);
            end
            if (n == 2) begin
                requireTrue("nRas not low 2 cycles after ts", nRas === 1'b0);
                compareValue("row", int'(a[20:11]), int'(cma));
            end
            if (nCas === 1'b0 && casAt < 0) begin
                casAt = n;
                compareValue("column", int'(a[10:1]), int'(cma));
                compareValue("nWe", 0, int'(nWe));
            end
            if (nTa === 1'b0) begin
                ackAt = n;
            end
        end
        compareValue("nCas cycle", 2 + rasToCas, casAt);
        compareValue("nTa cycle", 4 + rasToCas, ackAt);
        // Exactly one acknowledge
        for (k = 0; k < 3; k++) begin
            nextCycle();
            requireTrue("extra nTa after single write", nTa === 1'b1);
        end
        closeTest();
    endtask

    task automatic ramLineTest();
        int n;
        int acks;
        int beats;
        int lastCas;
        int rasUp;
        cpuAddrT a;
        ramAddrT expCol;
        logic [1:0] low;
        startTest("ramLine");
        a = cpuAddrT'($urandom);
        a[20] = 1'b0;
        issueTransfer(a, sizeLine, 1'b1, 2'b00);
        n = 0;
        acks = 0;
        beats = 0;
        lastCas = -1;
        rasUp = -1;
        while (acks < 4 && n < ackLimit) begin
            nextCycle();
            n++;
            requireTrue("nWe fell during read", nWe === 1'b1);
            if (nCas === 1'b0) begin
                // Low column bits wrap inside the line
                low = a[2:1] + 2'(beats);
                expCol = {a[10:3], low};
                compareValue($sformatf("column beat %0d", beats), int'(expCol), int'(cma));
                compareValue($sformatf("nCas cycle beat %0d", beats),
                             2 + rasToCas + 2 * beats, n);
                beats++;
                lastCas = n;
            end
            if (n >= 2 && nRas === 1'b1 && rasUp < 0) begin
                rasUp = n;
            end
            if (nTa === 1'b0) begin
                acks++;
            end
        end
        compareValue("nTa count", 4, acks);
        compareValue("CAS count", 4, beats);
        requireTrue("nRas did not rise after the fourth beat", rasUp > lastCas);
        nextCycle();
        requireTrue("extra nTa after line", nTa === 1'b1);
        closeTest();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        nTS = 1'b0;
        TS_RST = 1'b1;
        ts = 1'b0;
        addr = '0;
        siz = sizeLong;
        rnW = 1'b1;
        tt = 2'b00;
        nDtack = 1'b1;
        void'($urandom(32'h315e));
        resetStateTest();
        byteEnableTest();
        regAccessTest();
        regLineTest();
        ramWriteTest();
        ramLineTest();
        $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Sized from transfer count and the longest transfer
    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns, a test did not finish", watchdogNs);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- transferAck.sv
// 68040 transfer acknowledge and burst inhibit with last acknowledge flag
`timescale 1ns/10ps

module transferAck (
    input  logic nTS,
    input  logic TS_RST,
    input  logic regDone,
    input  logic ramBeat,
    input  logic tbiStart,
    input  logic burst,
    output logic nTa,
    output logic nTbi,
    output logic lastAck
);
    import u712Pkg::*;

    beatT beatCount;
    logic finalBeat;

    // Single beat, or fourth beat of a line
    assign finalBeat = ramBeat & (~burst | (beatCount == 2'd3));

    ////////////////////////////////////////////////////////////////////////////
    // Acknowledge registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge nTS or posedge TS_RST) begin
        if (TS_RST) begin
            nTa <= 1'b1;
            nTbi <= 1'b1;
            lastAck <= 1'b0;
            beatCount <= 2'd0;
        end else begin
            // One nTa per completion pulse
            nTa <= ~(regDone | ramBeat | tbiStart);
            // Line to register space, TA and TBI together
            nTbi <= ~tbiStart;
            lastAck <= regDone | tbiStart | finalBeat;
            // Burst beat count
            if (finalBeat) begin
                beatCount <= 2'd0;
            end else if (ramBeat && burst) begin
                beatCount <= beatCount + 2'd1;
            end
        end
    end

endmodule

//--- u712Pkg.sv
// Bus glue typedefs, transfer size and space encodings, cycle state enums
package u712Pkg;

    // CPU byte address on the local bus
    typedef logic [20:0] cpuAddrT;

    // Multiplexed chip RAM row or column
    typedef logic [9:0] ramAddrT;

    // Active-low byte enables, bit 3 is the upper-upper lane
    typedef logic [3:0] laneT;

    // 68040 SIZ[1:0]
    typedef logic [1:0] sizeT;

    // Line burst beat number
    typedef logic [1:0] beatT;

    ////////////////////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////////////////////

    localparam sizeT sizeLong = 2'b00;
    localparam sizeT sizeByte = 2'b01;
    localparam sizeT sizeWord = 2'b10;
    localparam sizeT sizeLine = 2'b11;

    // Address bit that selects chipset register space
    localparam int regSpaceBit = 20;

    // TT value of a normal access
    localparam logic [1:0] ttNormalAccess = 2'b00;

    ////////////////////////////////////////////////////////////////////////////
    // Cycle states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {regIdle, regStrobe, regWait, regEnd} regStateT;

    typedef enum logic [1:0] {ramIdle, ramRow, ramCas, ramPrecharge} ramStateT;

    // nRas to nCas in clocks
    localparam int rasToCasDefault = 1;

endpackage

//--- u712Top.sv
// Bus glue top level with decode, register and RAM cycles and acknowledge
`timescale 1ns/10ps

module u712Top #(
    parameter int rasToCas = u712Pkg::rasToCasDefault
) (
    input  logic             nTS,
    input  logic             TS_RST,
    input  logic             ts,
    input  u712Pkg::cpuAddrT addr,
    input  u712Pkg::sizeT    siz,
    input  logic             rnW,
    input  logic [1:0]       tt,
    input  logic             nDtack,
    output logic             nTa,
    output logic             nTbi,
    output logic             nAs,
    output logic             nUds,
    output logic             nLds,
    output logic             nUube,
    output logic             nUmbe,
    output logic             nLmbe,
    output logic             nLlbe,
    output logic             nRas,
    output logic             nCas,
    output logic             nWe,
    output u712Pkg::ramAddrT cma
);
    import u712Pkg::*;

    cpuAddrT reqAddr;
    laneT lanes;
    logic regStart;
    logic ramStart;
    logic tbiStart;
    logic reqRnW;
    logic reqBurst;
    logic lastAck;
    logic regDone;
    logic ramBeat;
    logic ttNormal;
    logic ramGo;
    logic ackBeat;
    logic ackBurst;

    ////////////////////////////////////////////////////////////////////////////
    // TT gating
    ////////////////////////////////////////////////////////////////////////////

    assign ttNormal = (tt == ttNormalAccess);
    assign ramGo = ramStart & ttNormal;
    // Other TT values get one ack with no RAM strobes
    assign ackBeat = ramBeat | (ramStart & ~ttNormal);
    assign ackBurst = reqBurst & ttNormal;

    assign nUube = lanes[3];
    assign nUmbe = lanes[2];
    assign nLmbe = lanes[1];
    assign nLlbe = lanes[0];

    // Decode
    cycleDecode uDecode (
        .nTS      (nTS),
        .TS_RST   (TS_RST),
        .ts       (ts),
        .addr     (addr),
        .siz      (siz),
        .rnW      (rnW),
        .lastAck  (lastAck),
        .regStart (regStart),
        .ramStart (ramStart),
        .tbiStart (tbiStart),
        .busy     (),
        .reqAddr  (reqAddr),
        .reqRnW   (reqRnW),
        .reqBurst (reqBurst),
        .lanes    (lanes)
    );

    // Chipset register cycle
    regCycle uRegCycle (
        .nTS      (nTS),
        .TS_RST   (TS_RST),
        .regStart (regStart),
        .lanes    (lanes),
        .rnW      (reqRnW),
        .nDtack   (nDtack),
        .nAs      (nAs),
        .nUds     (nUds),
        .nLds     (nLds),
        .regDone  (regDone)
    );

    // Chip RAM cycle
    ramCycle #(
        .rasToCas (rasToCas)
    ) uRamCycle (
        .nTS      (nTS),
        .TS_RST   (TS_RST),
        .ramStart (ramGo),
        .reqAddr  (reqAddr),
        .rnW      (reqRnW),
        .burst    (reqBurst),
        .nRas     (nRas),
        .nCas     (nCas),
        .nWe      (nWe),
        .cma      (cma),
        .ramBeat  (ramBeat)
    );

    // Result
    transferAck uTransferAck (
        .nTS      (nTS),
        .TS_RST   (TS_RST),
        .regDone  (regDone),
        .ramBeat  (ackBeat),
        .tbiStart (tbiStart),
        .burst    (ackBurst),
        .nTa      (nTa),
        .nTbi     (nTbi),
        .lastAck  (lastAck)
    );

endmodule
